// File: hdl/cp0_pkg.sv
package cp0_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

typedef logic [31:0] word_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [2:0]  reg_sel_t;
typedef logic [4:0]  exc_code_t;
typedef logic [7:0]  asid_t;
typedef logic [18:0] vpn2_t;
typedef logic [23:0] pfn_t;
typedef logic [2:0]  cache_attr_t;
typedef logic [2:0]  tlb_index_t;

localparam int TLB_ENTRIES = 8;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register numbers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam reg_sel_t SEL_MAIN = 3'd0;
localparam reg_sel_t SEL_EXT  = 3'd1;  // EBase and Config1 live here.

localparam reg_addr_t REG_INDEX     = 5'd0;
localparam reg_addr_t REG_RANDOM    = 5'd1;
localparam reg_addr_t REG_ENTRY_LO0 = 5'd2;
localparam reg_addr_t REG_ENTRY_LO1 = 5'd3;
localparam reg_addr_t REG_CONTEXT   = 5'd4;
localparam reg_addr_t REG_BAD_VADDR = 5'd8;
localparam reg_addr_t REG_COUNT     = 5'd9;
localparam reg_addr_t REG_ENTRY_HI  = 5'd10;
localparam reg_addr_t REG_COMPARE   = 5'd11;
localparam reg_addr_t REG_STATUS    = 5'd12;
localparam reg_addr_t REG_CAUSE     = 5'd13;
localparam reg_addr_t REG_EPC       = 5'd14;
localparam reg_addr_t REG_PRID      = 5'd15;
localparam reg_addr_t REG_CONFIG    = 5'd16;
localparam reg_addr_t REG_EBASE     = 5'd15;
localparam reg_addr_t REG_CONFIG1   = 5'd16;

// Status and Cause bit positions.
localparam int ST_IE    = 0;
localparam int ST_EXL   = 1;
localparam int ST_ERL   = 2;
localparam int CAUSE_BD = 31;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exception codes and constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam exc_code_t EXC_INT  = 5'd0;
localparam exc_code_t EXC_MOD  = 5'd1;
localparam exc_code_t EXC_TLBL = 5'd2;
localparam exc_code_t EXC_TLBS = 5'd3;
localparam exc_code_t EXC_ADEL = 5'd4;
localparam exc_code_t EXC_ADES = 5'd5;
localparam exc_code_t EXC_SYS  = 5'd8;
localparam exc_code_t EXC_BP   = 5'd9;
localparam exc_code_t EXC_RI   = 5'd10;
localparam exc_code_t EXC_OV   = 5'd12;

localparam word_t STATUS_RESET  = 32'h1040_0000;  // CU0 and BEV set.
localparam word_t EBASE_RESET   = 32'h8000_0000;
localparam word_t CONFIG0_VALUE = {1'b1, 21'b0, 3'd1, 4'b0, 3'd3};  // Standard TLB, K0 cached.
localparam word_t CONFIG1_VALUE = {1'b0, 6'(TLB_ENTRIES - 1), 3'd2, 3'd4, 3'd1,
	3'd2, 3'd4, 3'd1, 7'd0};
localparam word_t PRID_VALUE    = {8'h00, 8'h01, 16'h8000};

endpackage

// File: hdl/cp0_write_mask.sv
`timescale 1ns/100ps

module cp0_write_mask (
	input  cp0_pkg::reg_sel_t  sel,
	input  cp0_pkg::reg_addr_t addr,
	output cp0_pkg::word_t     mask
);
	import cp0_pkg::*;

	always_comb begin
		mask = '0;
		if (sel == SEL_MAIN) begin
			case (addr)
				REG_INDEX:     mask = 32'h0000_0007;  // Probe flag is read only.
				REG_ENTRY_LO0: mask = 32'h3fff_ffff;
				REG_ENTRY_LO1: mask = 32'h3fff_ffff;
				REG_CONTEXT:   mask = 32'hff80_0000;  // PTEBase only.
				REG_COUNT:     mask = 32'hffff_ffff;
				REG_ENTRY_HI:  mask = 32'hffff_e0ff;
				REG_COMPARE:   mask = 32'hffff_ffff;
				REG_STATUS:    mask = 32'h1040_ff1f;
				REG_CAUSE:     mask = 32'h0000_0300;  // Software interrupts.
				REG_EPC:       mask = 32'hffff_ffff;
				default:       mask = '0;
			endcase
		end else if (sel == SEL_EXT && addr == REG_EBASE) begin
			mask = 32'h3fff_f000;
		end
	end

endmodule

// File: hdl/cp0_except.sv
`timescale 1ns/100ps

module cp0_except (
	input  logic                valid,
	input  logic                eret,
	input  logic                delayslot,
	input  cp0_pkg::word_t      pc,
	input  cp0_pkg::word_t      extra,
	input  cp0_pkg::exc_code_t  code,
	input  logic                status_exl,
	input  logic                status_erl,
	output logic                epc_we,
	output logic                bd_value,
	output logic                exl_set,
	output logic                exl_clr,
	output logic                erl_clr,
	output logic                code_we,
	output logic                bad_vaddr_we,
	output logic                vpn_we,
	output cp0_pkg::word_t      epc_value
);
	import cp0_pkg::*;

	logic exc;
	logic addr_code;
	logic tlb_code;
	logic code_known;

	assign exc       = valid && !eret;
	assign addr_code = (code == EXC_ADEL) || (code == EXC_ADES);
	assign tlb_code  = (code == EXC_TLBL) || (code == EXC_TLBS);

	// ERET leaves error level first, then exception level.
	assign erl_clr = valid && eret && status_erl;
	assign exl_clr = valid && eret && !status_erl;

	assign exl_set      = exc;
	assign code_we      = exc;
	assign epc_we       = exc && !status_exl;  // Nested entry keeps the first EPC.
	assign epc_value    = delayslot ? pc - 32'd4 : pc;
	assign bd_value     = delayslot;
	assign bad_vaddr_we = exc && (addr_code || tlb_code);
	assign vpn_we       = exc && tlb_code;  // Refill also loads Context and EntryHi.

	always_comb begin
		case (code)
			EXC_INT, EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL,
			EXC_ADES, EXC_SYS, EXC_BP, EXC_RI, EXC_OV: code_known = 1'b1;
			default: code_known = 1'b0;
		endcase
	end

	// An exception from the pipeline must carry a code this block knows,
	// and an address fault must carry a defined address.
	always_comb begin
		if (exc) begin
			assert final (code_known && !(bad_vaddr_we && $isunknown(extra)))
				else $error("exception with unknown code %0d", code);
		end
	end

endmodule

// File: hdl/cp0_regs.sv
`timescale 1ns/100ps

module cp0_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  cp0_pkg::reg_addr_t    raddr,
	input  cp0_pkg::reg_sel_t     rsel,
	input  logic                  we,
	input  cp0_pkg::reg_addr_t    waddr,
	input  cp0_pkg::reg_sel_t     wsel,
	input  cp0_pkg::word_t        wdata,
	input  logic [7:0]            interrupt_flag,
	input  logic                  epc_we,
	input  cp0_pkg::word_t        epc_value,
	input  logic                  bd_value,
	input  logic                  exl_set,
	input  logic                  exl_clr,
	input  logic                  erl_clr,
	input  logic                  code_we,
	input  logic                  bad_vaddr_we,
	input  logic                  vpn_we,
	input  cp0_pkg::word_t        exc_extra,
	input  cp0_pkg::exc_code_t    exc_code,
	input  logic                  tlbr,
	input  logic                  tlbp,
	input  logic                  tlbwi,
	input  logic                  tlbwr,
	input  cp0_pkg::vpn2_t        rd_vpn2,
	input  cp0_pkg::asid_t        rd_asid,
	input  cp0_pkg::pfn_t         rd_pfn0,
	input  cp0_pkg::pfn_t         rd_pfn1,
	input  cp0_pkg::cache_attr_t  rd_c0,
	input  cp0_pkg::cache_attr_t  rd_c1,
	input  logic                  rd_d0,
	input  logic                  rd_d1,
	input  logic                  rd_v0,
	input  logic                  rd_v1,
	input  logic                  rd_g,
	input  logic                  probe_hit,
	input  cp0_pkg::tlb_index_t   probe_index,
	output cp0_pkg::word_t        rdata,
	output logic                  status_exl,
	output logic                  status_erl,
	output logic                  timer_int,
	output logic                  int_pending,
	output logic                  tlb_we,
	output cp0_pkg::tlb_index_t   tlb_index,
	output cp0_pkg::vpn2_t        wr_vpn2,
	output cp0_pkg::asid_t        wr_asid,
	output cp0_pkg::pfn_t         wr_pfn0,
	output cp0_pkg::pfn_t         wr_pfn1,
	output cp0_pkg::cache_attr_t  wr_c0,
	output cp0_pkg::cache_attr_t  wr_c1,
	output logic                  wr_d0,
	output logic                  wr_d1,
	output logic                  wr_v0,
	output logic                  wr_v1,
	output logic                  wr_g,
	output cp0_pkg::asid_t        asid,
	output logic                  user_mode
);
	import cp0_pkg::*;

	word_t index, entry_lo0, entry_lo1, context_reg;
	word_t bad_vaddr, count, entry_hi, compare;
	word_t status, cause, epc, ebase;
	tlb_index_t random;
	word_t wmask;
	logic wr_en;
	logic tlb_rd;
	logic tlb_pr;
	logic compare_wr;

	function automatic word_t merge(input word_t old);
		return (wdata & wmask) | (old & ~wmask);
	endfunction

	cp0_write_mask mask0 (
		.sel  (wsel),
		.addr (waddr),
		.mask (wmask)
	);

	assign wr_en      = we && !stall;
	assign tlb_rd     = tlbr && !stall;
	assign tlb_pr     = tlbp && !stall;
	assign compare_wr = wr_en && wsel == SEL_MAIN && waddr == REG_COMPARE;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register updates
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			index       <= '0;
			random      <= tlb_index_t'(TLB_ENTRIES - 1);
			entry_lo0   <= '0;
			entry_lo1   <= '0;
			context_reg <= '0;
			bad_vaddr   <= '0;
			count       <= '0;
			entry_hi    <= '0;
			compare     <= '0;
			status      <= STATUS_RESET;
			cause       <= '0;
			epc         <= '0;
			ebase       <= EBASE_RESET;
		end else begin
			count <= count + 32'd1;
			if (wr_en && wsel == SEL_MAIN) begin
				case (waddr)
					REG_INDEX:     index       <= merge(index);
					REG_ENTRY_LO0: entry_lo0   <= merge(entry_lo0);
					REG_ENTRY_LO1: entry_lo1   <= merge(entry_lo1);
					REG_CONTEXT:   context_reg <= merge(context_reg);
					REG_COUNT:     count       <= merge(count);
					REG_ENTRY_HI:  entry_hi    <= merge(entry_hi);
					REG_COMPARE:   compare     <= merge(compare);
					REG_STATUS:    status      <= merge(status);
					REG_CAUSE:     cause       <= merge(cause);
					REG_EPC:       epc         <= merge(epc);
					default:       ;
				endcase
			end
			if (wr_en && wsel == SEL_EXT && waddr == REG_EBASE) begin
				ebase <= merge(ebase);
			end
			if (tlb_rd) begin
				entry_hi  <= {rd_vpn2, 5'b0, rd_asid};
				entry_lo0 <= {2'b0, rd_pfn0, rd_c0, rd_d0, rd_v0, rd_g};
				entry_lo1 <= {2'b0, rd_pfn1, rd_c1, rd_d1, rd_v1, rd_g};
			end
			if (tlb_pr) begin
				index <= probe_hit ? word_t'(probe_index) : 32'h8000_0000;  // Miss sets P.
			end
			if (tlbwr && !stall) begin
				random <= random - 1'b1;
			end
			cause[15:10] <= {interrupt_flag[7] | timer_int, interrupt_flag[6:2]};

			// Exception entry and return win over a write in the same cycle.
			if (exl_set) status[ST_EXL] <= 1'b1;
			if (exl_clr) status[ST_EXL] <= 1'b0;
			if (erl_clr) status[ST_ERL] <= 1'b0;
			if (code_we) cause[6:2] <= exc_code;
			if (epc_we) begin
				epc             <= epc_value;
				cause[CAUSE_BD] <= bd_value;
			end
			if (bad_vaddr_we) bad_vaddr <= exc_extra;
			if (vpn_we) begin
				context_reg[22:4] <= exc_extra[31:13];
				entry_hi[31:13]   <= exc_extra[31:13];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			timer_int <= 1'b0;
		end else if (compare_wr) begin
			timer_int <= 1'b0;
		end else if (compare != '0 && compare == count) begin
			timer_int <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read mux and outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rdata = '0;
		if (rsel == SEL_MAIN) begin
			case (raddr)
				REG_INDEX:     rdata = index;
				REG_RANDOM:    rdata = word_t'(random);
				REG_ENTRY_LO0: rdata = entry_lo0;
				REG_ENTRY_LO1: rdata = entry_lo1;
				REG_CONTEXT:   rdata = context_reg;
				REG_BAD_VADDR: rdata = bad_vaddr;
				REG_COUNT:     rdata = count;
				REG_ENTRY_HI:  rdata = entry_hi;
				REG_COMPARE:   rdata = compare;
				REG_STATUS:    rdata = status;
				REG_CAUSE:     rdata = cause;
				REG_EPC:       rdata = epc;
				REG_PRID:      rdata = PRID_VALUE;
				REG_CONFIG:    rdata = CONFIG0_VALUE;
				default:       rdata = '0;
			endcase
		end else if (rsel == SEL_EXT) begin
			case (raddr)
				REG_EBASE:   rdata = ebase;
				REG_CONFIG1: rdata = CONFIG1_VALUE;
				default:     rdata = '0;
			endcase
		end
	end

	assign status_exl  = status[ST_EXL];
	assign status_erl  = status[ST_ERL];
	assign int_pending = status[ST_IE] && !status_exl && !status_erl &&
		|(cause[15:8] & status[15:8]);
	assign asid        = entry_hi[7:0];
	assign user_mode   = (status[4:1] == 4'b1000);  // KSU user, EXL and ERL clear.

	assign tlb_we    = (tlbwi || tlbwr) && !stall;
	assign tlb_index = tlbwr ? random : index[2:0];
	assign wr_vpn2   = entry_hi[31:13];
	assign wr_asid   = entry_hi[7:0];
	assign wr_pfn0   = entry_lo0[29:6];
	assign wr_c0     = entry_lo0[5:3];
	assign wr_d0     = entry_lo0[2];
	assign wr_v0     = entry_lo0[1];
	assign wr_pfn1   = entry_lo1[29:6];
	assign wr_c1     = entry_lo1[5:3];
	assign wr_d1     = entry_lo1[2];
	assign wr_v1     = entry_lo1[1];
	assign wr_g      = entry_lo0[0] & entry_lo1[0];  // Global needs both halves.

	// Only one TLB write source may be selected per instruction.
	assert property (@(posedge clk) disable iff (rst) !(tlbwi && tlbwr))
		else $error("tlbwi and tlbwr raised together");

endmodule

// File: hdl/tlb.sv
`timescale 1ns/100ps

module tlb (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  cp0_pkg::tlb_index_t   index,
	input  cp0_pkg::vpn2_t        wr_vpn2,
	input  cp0_pkg::asid_t        wr_asid,
	input  cp0_pkg::pfn_t         wr_pfn0,
	input  cp0_pkg::pfn_t         wr_pfn1,
	input  cp0_pkg::cache_attr_t  wr_c0,
	input  cp0_pkg::cache_attr_t  wr_c1,
	input  logic                  wr_d0,
	input  logic                  wr_d1,
	input  logic                  wr_v0,
	input  logic                  wr_v1,
	input  logic                  wr_g,
	input  cp0_pkg::vpn2_t        probe_vpn2,
	input  cp0_pkg::asid_t        probe_asid,
	output cp0_pkg::vpn2_t        rd_vpn2,
	output cp0_pkg::asid_t        rd_asid,
	output cp0_pkg::pfn_t         rd_pfn0,
	output cp0_pkg::pfn_t         rd_pfn1,
	output cp0_pkg::cache_attr_t  rd_c0,
	output cp0_pkg::cache_attr_t  rd_c1,
	output logic                  rd_d0,
	output logic                  rd_d1,
	output logic                  rd_v0,
	output logic                  rd_v1,
	output logic                  rd_g,
	output logic                  probe_hit,
	output cp0_pkg::tlb_index_t   probe_index
);
	import cp0_pkg::*;

	vpn2_t       vpn2_mem [TLB_ENTRIES];
	asid_t       asid_mem [TLB_ENTRIES];
	pfn_t        pfn0_mem [TLB_ENTRIES];
	pfn_t        pfn1_mem [TLB_ENTRIES];
	cache_attr_t c0_mem   [TLB_ENTRIES];
	cache_attr_t c1_mem   [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] d0_mem, d1_mem;
	logic [TLB_ENTRIES-1:0] v0_mem, v1_mem, g_mem;

	always_ff @(posedge clk) begin
		if (rst) begin
			v0_mem <= '0;
			v1_mem <= '0;
			g_mem  <= '0;
		end else if (we) begin
			v0_mem[index] <= wr_v0;
			v1_mem[index] <= wr_v1;
			g_mem[index]  <= wr_g;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			vpn2_mem[index] <= wr_vpn2;
			asid_mem[index] <= wr_asid;
			pfn0_mem[index] <= wr_pfn0;
			pfn1_mem[index] <= wr_pfn1;
			c0_mem[index]   <= wr_c0;
			c1_mem[index]   <= wr_c1;
			d0_mem[index]   <= wr_d0;
			d1_mem[index]   <= wr_d1;
		end
	end

	assign rd_vpn2 = vpn2_mem[index];
	assign rd_asid = asid_mem[index];
	assign rd_pfn0 = pfn0_mem[index];
	assign rd_pfn1 = pfn1_mem[index];
	assign rd_c0   = c0_mem[index];
	assign rd_c1   = c1_mem[index];
	assign rd_d0   = d0_mem[index];
	assign rd_d1   = d1_mem[index];
	assign rd_v0   = v0_mem[index];
	assign rd_v1   = v1_mem[index];
	assign rd_g    = g_mem[index];

	// Scan from the top so the lowest matching entry is the one kept.
	always_comb begin
		probe_hit   = 1'b0;
		probe_index = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (vpn2_mem[i] == probe_vpn2 && (asid_mem[i] == probe_asid || g_mem[i])) begin
				probe_hit   = 1'b1;
				probe_index = tlb_index_t'(i);
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(index))
		else $error("TLB write with unknown index");

endmodule

// File: hdl/cp0_subsys.sv
`timescale 1ns/100ps

module cp0_subsys (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  cp0_pkg::reg_addr_t   raddr,
	input  cp0_pkg::reg_sel_t    rsel,
	input  logic                 we,
	input  cp0_pkg::reg_addr_t   waddr,
	input  cp0_pkg::reg_sel_t    wsel,
	input  cp0_pkg::word_t       wdata,
	input  logic                 exc_valid,
	input  logic                 exc_eret,
	input  logic                 exc_delayslot,
	input  cp0_pkg::word_t       exc_pc,
	input  cp0_pkg::exc_code_t   exc_code,
	input  cp0_pkg::word_t       exc_extra,
	input  logic [7:0]           interrupt_flag,
	input  logic                 tlbr,
	input  logic                 tlbp,
	input  logic                 tlbwi,
	input  logic                 tlbwr,
	output cp0_pkg::word_t       rdata,
	output logic                 timer_int,
	output logic                 int_pending,
	output cp0_pkg::asid_t       asid,
	output logic                 user_mode
);
	import cp0_pkg::*;

	logic status_exl, status_erl;
	logic epc_we, bd_value, exl_set, exl_clr, erl_clr;
	logic code_we, bad_vaddr_we, vpn_we;
	word_t epc_value;
	logic tlb_we;
	tlb_index_t tlb_index;
	vpn2_t wr_vpn2, rd_vpn2;
	asid_t wr_asid, rd_asid;
	pfn_t wr_pfn0, wr_pfn1, rd_pfn0, rd_pfn1;
	cache_attr_t wr_c0, wr_c1, rd_c0, rd_c1;
	logic wr_d0, wr_d1, wr_v0, wr_v1, wr_g;
	logic rd_d0, rd_d1, rd_v0, rd_v1, rd_g;
	logic probe_hit;
	tlb_index_t probe_index;

	cp0_except except0 (
		.valid     (exc_valid),
		.eret      (exc_eret),
		.delayslot (exc_delayslot),
		.pc        (exc_pc),
		.extra     (exc_extra),
		.code      (exc_code),
		.status_exl, .status_erl,
		.epc_we, .bd_value, .exl_set, .exl_clr, .erl_clr,
		.code_we, .bad_vaddr_we, .vpn_we, .epc_value
	);

	cp0_regs regs0 (
		.clk, .rst, .stall,
		.raddr, .rsel, .we, .waddr, .wsel, .wdata,
		.interrupt_flag,
		.epc_we, .epc_value, .bd_value, .exl_set, .exl_clr, .erl_clr,
		.code_we, .bad_vaddr_we, .vpn_we, .exc_extra, .exc_code,
		.tlbr, .tlbp, .tlbwi, .tlbwr,
		.rd_vpn2, .rd_asid, .rd_pfn0, .rd_pfn1, .rd_c0, .rd_c1,
		.rd_d0, .rd_d1, .rd_v0, .rd_v1, .rd_g,
		.probe_hit, .probe_index,
		.rdata, .status_exl, .status_erl, .timer_int, .int_pending,
		.tlb_we, .tlb_index,
		.wr_vpn2, .wr_asid, .wr_pfn0, .wr_pfn1, .wr_c0, .wr_c1,
		.wr_d0, .wr_d1, .wr_v0, .wr_v1, .wr_g,
		.asid, .user_mode
	);

	// Probe key is the current EntryHi.
	tlb tlb0 (
		.clk, .rst,
		.we    (tlb_we),
		.index (tlb_index),
		.wr_vpn2, .wr_asid, .wr_pfn0, .wr_pfn1, .wr_c0, .wr_c1,
		.wr_d0, .wr_d1, .wr_v0, .wr_v1, .wr_g,
		.probe_vpn2 (wr_vpn2),
		.probe_asid (asid),
		.rd_vpn2, .rd_asid, .rd_pfn0, .rd_pfn1, .rd_c0, .rd_c1,
		.rd_d0, .rd_d1, .rd_v0, .rd_v1, .rd_g,
		.probe_hit, .probe_index
	);

endmodule

// File: test/cp0_subsys_tb.sv
`timescale 1ns/100ps

module cp0_subsys_tb;
	import cp0_pkg::*;

	typedef enum logic [3:0] {
		OP_WRITE, OP_STALL_WRITE, OP_READ, OP_EXC, OP_ERET, OP_TLB, OP_IDLE,
		OP_FLAG, OP_BIT, OP_MARK, OP_DELTA, OP_COMPARE_REL, OP_ASID
	} op_t;

	typedef struct packed {
		op_t       op;
		reg_addr_t addr;
		reg_sel_t  sel;
		word_t     data;
		word_t     exp;
	} step_t;

	localparam reg_addr_t TLB_R     = 5'd0;
	localparam reg_addr_t TLB_P     = 5'd1;
	localparam reg_addr_t TLB_WI    = 5'd2;
	localparam reg_addr_t TLB_WR    = 5'd3;
	localparam reg_addr_t BIT_TIMER = 5'd0;
	localparam reg_addr_t BIT_PEND  = 5'd1;
	localparam reg_addr_t BIT_USER  = 5'd2;

	logic clk, rst, stall, we;
	reg_addr_t raddr, waddr;
	reg_sel_t rsel, wsel;
	word_t wdata, exc_pc, exc_extra, rdata;
	logic exc_valid, exc_eret, exc_delayslot;
	exc_code_t exc_code;
	logic [7:0] interrupt_flag;
	logic tlbr, tlbp, tlbwi, tlbwr;
	logic timer_int, int_pending, user_mode;
	asid_t asid;

	step_t steps[$];
	word_t lcg_state = 32'd47962;
	word_t count_mark;
	int cycles = 0;
	int limit = 200;

	cp0_subsys dut0 (
		.clk, .rst, .stall,
		.raddr, .rsel, .we, .waddr, .wsel, .wdata,
		.exc_valid, .exc_eret, .exc_delayslot, .exc_pc, .exc_code, .exc_extra,
		.interrupt_flag, .tlbr, .tlbp, .tlbwi, .tlbwr,
		.rdata, .timer_int, .int_pending, .asid, .user_mode
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Finished with errors");
			$fatal(1, "Timeout: the step table did not finish within %0d cycles", limit);
		end
	end

	function word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_asid(input asid_t got, input asid_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic add_step(input op_t op, input reg_addr_t addr, input reg_sel_t sel,
		input word_t data, input word_t exp);
		step_t s;
		s = '{op: op, addr: addr, sel: sel, data: data, exp: exp};
		steps.push_back(s);
	endtask

	task automatic add_write(input reg_addr_t addr, input word_t data);
		add_step(OP_WRITE, addr, SEL_MAIN, data, '0);
	endtask

	task automatic add_read(input reg_addr_t addr, input word_t exp);
		add_step(OP_READ, addr, SEL_MAIN, '0, exp);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Step table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic build_table();
		word_t hi;
		word_t lo0;
		word_t lo1;
		word_t bad;
		int rnd;
		add_write(REG_STATUS, 32'hffff_ffff);
		add_read(REG_STATUS, 32'h1040_ff1f);
		add_write(REG_STATUS, 32'h1040_0000);
		add_read(REG_STATUS, 32'h1040_0000);
		add_write(REG_ENTRY_LO0, 32'hffff_ffff);
		add_read(REG_ENTRY_LO0, 32'h3fff_ffff);
		add_write(REG_CAUSE, 32'hffff_ffff);
		add_read(REG_CAUSE, 32'h0000_0300);  // Only the software interrupt bits.
		add_write(REG_CAUSE, 32'h0);
		add_read(REG_CAUSE, 32'h0);
		add_write(REG_PRID, 32'hffff_ffff);
		add_read(REG_PRID, 32'h0001_8000);
		add_write(REG_CONFIG, 32'hffff_ffff);
		add_read(REG_CONFIG, 32'h8000_0083);
		add_write(REG_BAD_VADDR, 32'hffff_ffff);
		add_read(REG_BAD_VADDR, 32'h0);
		add_step(OP_STALL_WRITE, REG_EPC, SEL_MAIN, 32'h1234_5678, '0);
		add_read(REG_EPC, 32'h0);

		// Exception entry from a delay slot, then a nested TLB refill.
		add_step(OP_EXC, EXC_SYS, 3'd1, 32'h8000_1000, '0);
		add_read(REG_EPC, 32'h8000_1000 - 32'd4);
		add_read(REG_CAUSE, {1'b1, 24'b0, EXC_SYS, 2'b0});
		add_read(REG_STATUS, 32'h1040_0002);
		bad = 32'h1234_6abc;
		add_step(OP_EXC, EXC_TLBL, 3'd0, 32'h8000_2000, bad);
		add_read(REG_EPC, 32'h8000_1000 - 32'd4);
		add_read(REG_CAUSE, {1'b1, 24'b0, EXC_TLBL, 2'b0});
		add_read(REG_BAD_VADDR, bad);
		add_read(REG_CONTEXT, (bad >> 13) << 4);
		add_read(REG_ENTRY_HI, bad & 32'hffff_e000);
		add_step(OP_ERET, 5'd0, 3'd0, '0, '0);
		add_read(REG_STATUS, 32'h1040_0000);
		add_write(REG_STATUS, 32'h1040_0006);
		add_read(REG_STATUS, 32'h1040_0006);
		add_step(OP_ERET, 5'd0, 3'd0, '0, '0);
		add_read(REG_STATUS, 32'h1040_0002);  // ERL goes first.
		add_step(OP_ERET, 5'd0, 3'd0, '0, '0);
		add_read(REG_STATUS, 32'h1040_0000);

		// TLB round trip at entry 3, G kept clear.
		hi = (lcg_next() | 32'h0008_0000) & 32'hffff_e0ff;
		lo0 = lcg_next() & 32'h3fff_fffe;
		lo1 = lcg_next() & 32'h3fff_fffe;
		add_write(REG_ENTRY_HI, hi);
		add_write(REG_ENTRY_LO0, lo0);
		add_write(REG_ENTRY_LO1, lo1);
		add_write(REG_INDEX, 32'd3);
		add_read(REG_INDEX, 32'd3);
		add_step(OP_TLB, TLB_WI, 3'd0, '0, '0);
		add_write(REG_INDEX, 32'd0);
		add_step(OP_TLB, TLB_P, 3'd0, '0, '0);
		add_read(REG_INDEX, 32'd3);
		add_write(REG_ENTRY_LO0, 32'h0);
		add_write(REG_ENTRY_LO1, 32'h0);
		add_write(REG_ENTRY_HI, 32'h0);
		add_step(OP_TLB, TLB_R, 3'd0, '0, '0);
		add_read(REG_ENTRY_LO0, lo0);
		add_read(REG_ENTRY_LO1, lo1);
		add_read(REG_ENTRY_HI, hi);
		add_write(REG_ENTRY_HI, hi ^ 32'h0000_0001);
		add_step(OP_ASID, REG_ENTRY_HI, SEL_MAIN, '0, (hi ^ 32'h0000_0001) & 32'h0000_00ff);
		add_step(OP_TLB, TLB_P, 3'd0, '0, '0);
		add_read(REG_INDEX, 32'h8000_0000);
		rnd = TLB_ENTRIES - 1;
		add_read(REG_RANDOM, word_t'(rnd));
		for (int k = 0; k < TLB_ENTRIES; k++) begin
			rnd = (rnd == 0) ? TLB_ENTRIES - 1 : rnd - 1;
			add_step(OP_TLB, TLB_WR, 3'd0, '0, '0);
			add_read(REG_RANDOM, word_t'(rnd));
		end

		// Count, then the timer with Compare 12 ahead of the mark.
		add_step(OP_MARK, REG_COUNT, SEL_MAIN, '0, '0);
		add_step(OP_IDLE, 5'd0, 3'd0, 32'd9, '0);
		add_step(OP_DELTA, REG_COUNT, SEL_MAIN, '0, 32'd10);  // Idle plus its own cycle.
		add_step(OP_MARK, REG_COUNT, SEL_MAIN, '0, '0);
		add_step(OP_COMPARE_REL, REG_COMPARE, SEL_MAIN, 32'd12, '0);
		add_step(OP_IDLE, 5'd0, 3'd0, 32'd10, '0);
		add_step(OP_BIT, BIT_TIMER, 3'd0, '0, 32'd0);
		add_step(OP_BIT, BIT_TIMER, 3'd0, '0, 32'd1);
		add_read(REG_CAUSE, {1'b1, 15'b0, 1'b1, 8'b0, EXC_TLBL, 2'b0});
		add_write(REG_COMPARE, 32'h0);
		add_step(OP_BIT, BIT_TIMER, 3'd0, '0, 32'd0);

		// Hardware line 2 under IM2.
		add_write(REG_STATUS, 32'h1040_0401);
		add_step(OP_FLAG, 5'd0, 3'd0, 32'h04, '0);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd1);
		add_step(OP_FLAG, 5'd0, 3'd0, 32'h08, '0);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd0);
		add_step(OP_FLAG, 5'd0, 3'd0, 32'h04, '0);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd1);
		add_write(REG_STATUS, 32'h1040_0403);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd0);
		add_write(REG_STATUS, 32'h1040_0400);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd0);
		add_write(REG_STATUS, 32'h1040_0401);
		add_step(OP_BIT, BIT_PEND, 3'd0, '0, 32'd1);

		// User mode from KSU, only outside exception level.
		add_write(REG_STATUS, 32'h1040_0411);
		add_step(OP_BIT, BIT_USER, 3'd0, '0, 32'd1);
		add_write(REG_STATUS, 32'h1040_0413);
		add_step(OP_BIT, BIT_USER, 3'd0, '0, 32'd0);
		add_write(REG_STATUS, 32'h1040_0409);
		add_step(OP_BIT, BIT_USER, 3'd0, '0, 32'd0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Step execution
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_step(input step_t s, input int idx);
		string what;
		what = $sformatf("step %0d reg %0d", idx, s.addr);
		@(posedge clk);
		we        <= 1'b0;  // Strobes last one cycle.
		stall     <= 1'b0;
		exc_valid <= 1'b0;
		exc_eret  <= 1'b0;
		tlbr      <= 1'b0;
		tlbp      <= 1'b0;
		tlbwi     <= 1'b0;
		tlbwr     <= 1'b0;
		case (s.op)
			OP_WRITE, OP_STALL_WRITE: begin
				we    <= 1'b1;
				stall <= (s.op == OP_STALL_WRITE);
				waddr <= s.addr;
				wsel  <= s.sel;
				wdata <= s.data;
			end
			OP_READ: begin
				raddr <= s.addr;
				rsel  <= s.sel;
				@(negedge clk);
				check_word(rdata, s.exp, what);
			end
			OP_EXC: begin
				exc_valid     <= 1'b1;
				exc_code      <= s.addr;
				exc_delayslot <= s.sel[0];
				exc_pc        <= s.data;
				exc_extra     <= s.exp;
			end
			OP_ERET: begin
				exc_valid <= 1'b1;
				exc_eret  <= 1'b1;
			end
			OP_TLB: begin
				tlbr  <= (s.addr == TLB_R);
				tlbp  <= (s.addr == TLB_P);
				tlbwi <= (s.addr == TLB_WI);
				tlbwr <= (s.addr == TLB_WR);
			end
			OP_IDLE: repeat (s.data - 1) @(posedge clk);
			OP_FLAG: interrupt_flag <= s.data[7:0];
			OP_BIT: begin
				@(negedge clk);
				if (s.addr == BIT_TIMER)
					check_bit(timer_int, s.exp[0], {what, " timer_int"});
				else if (s.addr == BIT_PEND)
					check_bit(int_pending, s.exp[0], {what, " int_pending"});
				else
					check_bit(user_mode, s.exp[0], {what, " user_mode"});
			end
			OP_ASID: begin
				@(negedge clk);
				check_asid(asid, s.exp[7:0], {what, " asid"});
			end
			OP_MARK, OP_DELTA: begin
				raddr <= s.addr;
				rsel  <= s.sel;
				@(negedge clk);
				if (s.op == OP_MARK)
					count_mark = rdata;
				else
					check_word(rdata - count_mark, s.exp, {what, " Count delta"});
			end
			OP_COMPARE_REL: begin
				we    <= 1'b1;
				waddr <= s.addr;
				wsel  <= s.sel;
				wdata <= count_mark + s.data;
			end
			default: ;
		endcase
	endtask

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		stall          = 1'b0;
		raddr          = '0;
		rsel           = '0;
		we             = 1'b0;
		waddr          = '0;
		wsel           = '0;
		wdata          = '0;
		exc_valid      = 1'b0;
		exc_eret       = 1'b0;
		exc_delayslot  = 1'b0;
		exc_pc         = '0;
		exc_code       = EXC_INT;
		exc_extra      = '0;
		interrupt_flag = '0;
		tlbr           = 1'b0;
		tlbp           = 1'b0;
		tlbwi          = 1'b0;
		tlbwr          = 1'b0;
		build_table();
		limit = steps.size() * 4 + 200;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		foreach (steps[i]) begin
			run_step(steps[i], i);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: files.f
hdl/cp0_pkg.sv
hdl/cp0_write_mask.sv
hdl/cp0_except.sv
hdl/cp0_regs.sv
hdl/tlb.sv
hdl/cp0_subsys.sv
test/cp0_subsys_tb.sv

// File: Makefile
TOP = cp0_subsys_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
